//--- common/dma_pkg.sv
// Shared sizes, request and command structs, opcodes and controller states for the DMA engine
`default_nettype none

package dma_pkg;

  //////////////////////////////////////////////////
  // Table and memory sizes
  //////////////////////////////////////////////////

  // Number of request table entries
  localparam int dma_entries = 4;
  // Entry index width
  localparam int dma_ptr_w   = $clog2(dma_entries);
  // Word address, 256 words of local memory
  localparam int dma_addr_w  = 8;
  // Transfer length in words
  localparam int dma_size_w  = 8;
  // Memory word width
  localparam int dma_data_w  = 32;

  //////////////////////////////////////////////////
  // Request and command formats
  //////////////////////////////////////////////////

  // One table entry, 25 bits
  // dir 0 copies laddr -> raddr, dir 1 copies raddr -> laddr
  typedef struct packed {
    logic [dma_addr_w-1:0] laddr;
    logic [dma_addr_w-1:0] raddr;
    logic [dma_size_w-1:0] size;
    logic                  dir;
  } dma_req_t;

  // Field select, a set bit lets that field be overwritten
  typedef struct packed {
    logic laddr;
    logic raddr;
    logic size;
    logic dir;
  } dma_sel_t;

  // Host command opcodes
  typedef enum logic [1:0] {
    op_write,
    op_start,
    op_cancel,
    op_ack
  } dma_op_e;

  // Host command word
  typedef struct packed {
    dma_op_e                op;
    logic [dma_ptr_w-1:0]   pos;
    dma_sel_t               sel;
    dma_req_t               req;
  } dma_cmd_t;

  // Memory access, shared by engine and host ports
  typedef struct packed {
    logic                  we;
    logic [dma_addr_w-1:0] addr;
    logic [dma_data_w-1:0] wdata;
  } mem_req_t;

  // Copy engine FSM
  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_read,
    st_write,
    st_finish
  } dma_state_e;

endpackage

`default_nettype wire

//--- dma_table/dma_transfer_table.sv
// Request table with field-masked writes and per-entry valid, done and interrupt status
`default_nettype none

module dma_transfer_table
  import dma_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,

  // Host side, from the command decoder
  input  wire logic                   wr_en,
  input  wire logic [dma_ptr_w-1:0]   wr_pos,
  input  wire dma_sel_t               wr_sel,
  input  wire dma_req_t               wr_req,
  input  wire logic                   valid_en,
  input  wire logic [dma_ptr_w-1:0]   valid_pos,
  input  wire logic                   valid_set,
  input  wire logic                   ack_en,

  // Controller side
  input  wire logic [dma_ptr_w-1:0]   read_pos,
  output dma_req_t                    read_req,
  input  wire logic                   done_en,
  input  wire logic [dma_ptr_w-1:0]   done_pos,

  // Status
  output logic      [dma_entries-1:0] pending,
  output logic      [dma_entries-1:0] irq
);

  // Request storage
  dma_req_t req_mem [dma_entries];

  // Per-entry status bits
  logic [dma_entries-1:0] entry_valid;
  logic [dma_entries-1:0] entry_done;

  // Bit mask expanded from the field select
  dma_req_t wr_mask;

  always_comb begin
    wr_mask.laddr = {dma_addr_w{wr_sel.laddr}};
    wr_mask.raddr = {dma_addr_w{wr_sel.raddr}};
    wr_mask.size  = {dma_size_w{wr_sel.size}};
    wr_mask.dir   = wr_sel.dir;
  end

  //////////////////////////////////////////////////
  // Storage update
  //////////////////////////////////////////////////

  // Unselected fields keep their old value
  always_ff @(posedge clk) begin
    if (wr_en) begin
      req_mem[wr_pos] <= (req_mem[wr_pos] & ~wr_mask) | (wr_req & wr_mask);
    end
  end

  //////////////////////////////////////////////////
  // Status update
  //////////////////////////////////////////////////

  // Priority: start/cancel, then ack, then done from the engine
  always_ff @(posedge clk) begin
    if (rst) begin
      entry_valid <= '0;
      entry_done  <= '0;
    end else begin
      for (int i = 0; i < dma_entries; i++) begin
        if (valid_en && valid_pos == dma_ptr_w'(i)) begin
          entry_valid[i] <= valid_set;
          entry_done[i]  <= 1'b0;
        end else if (ack_en && valid_pos == dma_ptr_w'(i) && entry_done[i]) begin
          // Ack only releases a finished entry
          entry_valid[i] <= 1'b0;
          entry_done[i]  <= 1'b0;
        end else if (done_en && done_pos == dma_ptr_w'(i)) begin
          entry_done[i]  <= 1'b1;
        end
      end
    end
  end

  // Combinational lookup for the controller
  assign read_req = req_mem[read_pos];

  // Started but not yet copied
  assign pending = entry_valid & ~entry_done;
  // Held until the host acks or cancels
  assign irq     = entry_valid & entry_done;

endmodule

`default_nettype wire

//--- hdl/dma_cmd_decode.sv
// Command decoder from host opcodes to request table strobes
`default_nettype none

module dma_cmd_decode
  import dma_pkg::*;
(
  // Host command port, one command per cycle
  input  wire logic                 cmd_valid,
  input  wire dma_cmd_t             cmd,

  // Field write into the table
  output logic                      wr_en,
  output logic [dma_ptr_w-1:0]      wr_pos,
  output dma_sel_t                  wr_sel,
  output dma_req_t                  wr_req,

  // Start, cancel and ack strobes
  output logic                      valid_en,
  output logic [dma_ptr_w-1:0]      valid_pos,
  output logic                      valid_set,
  output logic                      ack_en
);

  // Opcode hits
  logic is_write;
  logic is_start;
  logic is_cancel;
  logic is_ack;

  always_comb begin
    is_write  = 1'b0;
    is_start  = 1'b0;
    is_cancel = 1'b0;
    is_ack    = 1'b0;
    if (cmd_valid) begin
      unique case (cmd.op)
        op_write:  is_write  = 1'b1;
        op_start:  is_start  = 1'b1;
        op_cancel: is_cancel = 1'b1;
        op_ack:    is_ack    = 1'b1;
        default:   is_write  = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Table strobes
  //////////////////////////////////////////////////

  // Masked field write
  assign wr_en     = is_write;
  assign wr_pos    = cmd.pos;
  assign wr_sel    = cmd.sel;
  assign wr_req    = cmd.req;

  // Start and cancel share one strobe, set level picks which
  assign valid_en  = is_start | is_cancel;
  assign valid_set = is_start;

  // Ack reuses the valid index
  assign valid_pos = cmd.pos;
  assign ack_en    = is_ack;

endmodule

`default_nettype wire

//--- hdl/dma_ctrl.sv
// Round-robin entry scheduler and word-copy FSM driving the engine memory port
`default_nettype none

module dma_ctrl
  import dma_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,

  // Table interface
  input  wire logic [dma_entries-1:0] pending,
  input  wire dma_req_t               read_req,
  output logic      [dma_ptr_w-1:0]   read_pos,
  output logic                        done_en,
  output logic      [dma_ptr_w-1:0]   done_pos,

  // Engine memory port
  output logic                        eng_valid,
  output mem_req_t                    eng_req,
  input  wire logic [dma_data_w-1:0]  eng_rdata
);

  dma_state_e state;

  // Entry being served and last one finished
  logic [dma_ptr_w-1:0]  cur_pos;
  logic [dma_ptr_w-1:0]  last_pos;
  logic [dma_ptr_w-1:0]  next_pos;

  // Latched request and word counter
  dma_req_t              req_q;
  logic [dma_size_w-1:0] cnt;

  // Copy addresses for the current word
  logic [dma_addr_w-1:0] src_addr;
  logic [dma_addr_w-1:0] dst_addr;

  //////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////

  // Scan from far to near so the entry right after last wins
  function automatic logic [dma_ptr_w-1:0] rr_pick(
    input logic [dma_entries-1:0] req,
    input logic [dma_ptr_w-1:0]   last
  );
    logic [dma_ptr_w-1:0] idx;
    logic [dma_ptr_w-1:0] pick;
    pick = last;
    for (int k = dma_entries; k >= 1; k--) begin
      idx = last + dma_ptr_w'(k);
      if (req[idx]) pick = idx;
    end
    return pick;
  endfunction

  assign next_pos = rr_pick(pending, last_pos);

  //////////////////////////////////////////////////
  // Copy FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      cur_pos  <= '0;
      last_pos <= {dma_ptr_w{1'b1}};
      cnt      <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          if (|pending) begin
            cur_pos <= next_pos;
            state   <= st_load;
          end
        end
        st_load: begin
          // Zero length goes straight to completion
          cnt   <= '0;
          state <= (read_req.size == '0) ? st_finish : st_read;
        end
        st_read: begin
          state <= st_write;
        end
        st_write: begin
          cnt   <= cnt + 1'b1;
          state <= (cnt + 1'b1 == req_q.size) ? st_finish : st_read;
        end
        st_finish: begin
          last_pos <= cur_pos;
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Request snapshot, later host writes do not disturb a running copy
  always_ff @(posedge clk) begin
    if (state == st_load) begin
      req_q <= read_req;
    end
  end

  // Direction picks source and destination, 8-bit sum wraps at memory size
  assign src_addr = (req_q.dir ? req_q.raddr : req_q.laddr) + cnt;
  assign dst_addr = (req_q.dir ? req_q.laddr : req_q.raddr) + cnt;

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign read_pos = cur_pos;
  assign done_pos = cur_pos;
  assign done_en  = (state == st_finish);

  // Read in st_read, write back the returned word in st_write
  always_comb begin
    eng_valid     = 1'b0;
    eng_req.we    = 1'b0;
    eng_req.addr  = src_addr;
    eng_req.wdata = eng_rdata;
    if (state == st_read) begin
      eng_valid = 1'b1;
    end else if (state == st_write) begin
      eng_valid    = 1'b1;
      eng_req.we   = 1'b1;
      eng_req.addr = dst_addr;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dma_local_mem.sv
// Single-port word memory with fixed engine priority over the host port
`default_nettype none

module dma_local_mem
  import dma_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,

  // Engine port, always granted
  input  wire logic                  eng_valid,
  input  wire mem_req_t              eng_req,
  output logic      [dma_data_w-1:0] eng_rdata,

  // Host port with back-pressure
  input  wire logic                  host_valid,
  input  wire mem_req_t              host_req,
  output logic                       host_ready,
  output logic      [dma_data_w-1:0] host_rdata,
  output logic                       host_rvalid
);

  logic [dma_data_w-1:0] mem [2**dma_addr_w];

  // Host only gets the array when the engine is quiet
  assign host_ready = ~eng_valid;

  // One access per cycle, read data registered per port
  always_ff @(posedge clk) begin
    if (eng_valid) begin
      if (eng_req.we) mem[eng_req.addr] <= eng_req.wdata;
      else            eng_rdata <= mem[eng_req.addr];
    end else if (host_valid) begin
      if (host_req.we) mem[host_req.addr] <= host_req.wdata;
      else             host_rdata <= mem[host_req.addr];
    end
  end

  // Read strobe one cycle after an accepted host read
  always_ff @(posedge clk) begin
    if (rst) host_rvalid <= 1'b0;
    else     host_rvalid <= host_valid & host_ready & ~host_req.we;
  end

endmodule

`default_nettype wire

//--- hdl/dma_top.sv
// DMA engine top with command decoder, request table, copy controller and local memory
`default_nettype none

module dma_top
  import dma_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,

  // Host command port
  input  wire logic                   cmd_valid,
  input  wire dma_cmd_t               cmd,

  // Host memory port
  input  wire logic                   host_valid,
  input  wire mem_req_t               host_req,
  output logic                        host_ready,
  output logic      [dma_data_w-1:0]  host_rdata,
  output logic                        host_rvalid,

  // Per-entry completion interrupts
  output logic      [dma_entries-1:0] irq
);

  // Decoder to table
  logic                 wr_en;
  logic [dma_ptr_w-1:0] wr_pos;
  dma_sel_t             wr_sel;
  dma_req_t             wr_req;
  logic                 valid_en;
  logic [dma_ptr_w-1:0] valid_pos;
  logic                 valid_set;
  logic                 ack_en;

  // Table and controller
  logic [dma_entries-1:0] pending;
  dma_req_t               read_req;
  logic [dma_ptr_w-1:0]   read_pos;
  logic                   done_en;
  logic [dma_ptr_w-1:0]   done_pos;

  // Engine memory port
  logic                  eng_valid;
  mem_req_t              eng_req;
  logic [dma_data_w-1:0] eng_rdata;

  dma_cmd_decode u_decode (
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .wr_en     (wr_en),
    .wr_pos    (wr_pos),
    .wr_sel    (wr_sel),
    .wr_req    (wr_req),
    .valid_en  (valid_en),
    .valid_pos (valid_pos),
    .valid_set (valid_set),
    .ack_en    (ack_en)
  );

  dma_transfer_table u_table (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_pos    (wr_pos),
    .wr_sel    (wr_sel),
    .wr_req    (wr_req),
    .valid_en  (valid_en),
    .valid_pos (valid_pos),
    .valid_set (valid_set),
    .ack_en    (ack_en),
    .read_pos  (read_pos),
    .read_req  (read_req),
    .done_en   (done_en),
    .done_pos  (done_pos),
    .pending   (pending),
    .irq       (irq)
  );

  dma_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .pending   (pending),
    .read_req  (read_req),
    .read_pos  (read_pos),
    .done_en   (done_en),
    .done_pos  (done_pos),
    .eng_valid (eng_valid),
    .eng_req   (eng_req),
    .eng_rdata (eng_rdata)
  );

  dma_local_mem u_mem (
    .clk         (clk),
    .rst         (rst),
    .eng_valid   (eng_valid),
    .eng_req     (eng_req),
    .eng_rdata   (eng_rdata),
    .host_valid  (host_valid),
    .host_req    (host_req),
    .host_ready  (host_ready),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid)
  );

endmodule

`default_nettype wire

//--- tb/dma_checker.sv
// Bound assertions on interrupt, completion, host arbitration and reset state of the DMA top
`default_nettype none

module dma_checker
  import dma_pkg::*;
(
  input wire logic                   clk,
  input wire logic                   rst,
  input wire logic [dma_entries-1:0] irq,
  input wire logic                   done_en,
  input wire logic [dma_ptr_w-1:0]   done_pos,
  input wire logic                   eng_valid,
  input wire logic                   host_valid,
  input wire mem_req_t               host_req,
  input wire logic                   host_ready,
  input wire logic                   host_rvalid
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failure counts per rule
  int fail_irq = 0;
  int fail_arb = 0;
  int fail_rd  = 0;
  int fail_rst = 0;
  int fail_total;

  assign fail_total = fail_irq + fail_arb + fail_rd + fail_rst;

  // One-hot of the entry the engine marks done
  logic [dma_entries-1:0] done_hot;

  assign done_hot = done_en ? (dma_entries'(1) << done_pos) : '0;

  //////////////////////////////////////////////////
  // Rules
  //////////////////////////////////////////////////

  // Every newly set irq bit had a done pulse one cycle earlier
  assert property (@(posedge clk) disable iff (rst)
    ((irq & ~$past(irq)) & ~$past(done_hot)) == '0)
  else begin
    $error("irq bit rose without a done pulse for that entry");
    fail_irq++;
  end

  // Engine always wins the memory
  assert property (@(posedge clk) disable iff (rst) eng_valid |-> !host_ready)
  else begin
    $error("host_ready high while the engine owns the memory");
    fail_arb++;
  end

  // Read strobe exactly one cycle after an accepted host read, never otherwise
  assert property (@(posedge clk) disable iff (rst)
    host_rvalid == $past(host_valid && host_ready && !host_req.we))
  else begin
    $error("host_rvalid does not follow an accepted host read");
    fail_rd++;
  end

  assert property (@(posedge clk) rst |=> (irq == '0))
  else begin
    $error("irq not cleared after reset");
    fail_rst++;
  end

endmodule

bind dma_top dma_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .irq         (irq),
  .done_en     (done_en),
  .done_pos    (done_pos),
  .eng_valid   (eng_valid),
  .host_valid  (host_valid),
  .host_req    (host_req),
  .host_ready  (host_ready),
  .host_rvalid (host_rvalid)
);

`default_nettype wire

//--- tb/dma_tb.sv
// Testbench for the DMA engine with host memory traffic, copy reference model and data checks
`default_nettype none

module dma_tb
  import dma_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Cycles any single wait may take before it counts as a hang
  localparam int wait_limit = 500;

  logic                   clk;
  logic                   rst;
  logic                   cmd_valid;
  dma_cmd_t               cmd;
  logic                   host_valid;
  mem_req_t               host_req;
  logic                   host_ready;
  logic [dma_data_w-1:0]  host_rdata;
  logic                   host_rvalid;
  logic [dma_entries-1:0] irq;

  // Expected memory contents, only written words are ever compared
  logic [dma_data_w-1:0] ref_mem [2**dma_addr_w];
  int                    errors;

  dma_top UUT (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .host_valid  (host_valid),
    .host_req    (host_req),
    .host_ready  (host_ready),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .irq         (irq)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Checks and reference model
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  function automatic dma_req_t make_req(
    input logic [dma_addr_w-1:0] laddr,
    input logic [dma_addr_w-1:0] raddr,
    input logic [dma_size_w-1:0] size,
    input logic                  dir
  );
    dma_req_t r;
    r.laddr = laddr;
    r.raddr = raddr;
    r.size  = size;
    r.dir   = dir;
    return r;
  endfunction

  // Word by word in engine order, addresses wrap at 256
  task automatic model_copy(input dma_req_t r);
    logic [dma_addr_w-1:0] src;
    logic [dma_addr_w-1:0] dst;
    src = r.dir ? r.raddr : r.laddr;
    dst = r.dir ? r.laddr : r.raddr;
    for (int k = 0; k < int'(r.size); k++) begin
      ref_mem[dst + 8'(k)] = ref_mem[src + 8'(k)];
    end
  endtask

  //////////////////////////////////////////////////
  // Host memory port
  //////////////////////////////////////////////////

  // Ready is sampled at the falling edge, where it is stable
  task automatic mem_access(input logic we, input logic [dma_addr_w-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    mem_req_t r;
    int       n;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    rdata   = '0;
    @(posedge clk);
    host_valid <= 1'b1;
    host_req   <= r;
    n = 0;
    @(negedge clk);
    while (!host_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!host_ready) begin
      $display("Host access to address %h was never accepted", addr);
      errors++;
    end
    @(posedge clk);
    host_valid <= 1'b0;
    if (!we) begin
      n = 0;
      @(negedge clk);
      while (!host_rvalid && n < wait_limit) begin
        @(negedge clk);
        n++;
      end
      if (!host_rvalid) begin
        $display("No read data returned for address %h", addr);
        errors++;
      end
      rdata = host_rdata;
    end
  endtask

  task automatic host_write(input logic [dma_addr_w-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    mem_access(1'b1, addr, data, unused);
    ref_mem[addr] = data;
  endtask

  // Random words at the copy source
  task automatic preload_source(input dma_req_t r);
    logic [dma_addr_w-1:0] base;
    base = r.dir ? r.raddr : r.laddr;
    for (int i = 0; i < int'(r.size); i++) begin
      host_write(base + 8'(i), $urandom());
    end
  endtask

  task automatic verify_range(input string name, input logic [dma_addr_w-1:0] base,
                              input int len);
    logic [dma_addr_w-1:0] a;
    logic [31:0]           rd;
    for (int i = 0; i < len; i++) begin
      a = base + 8'(i);
      mem_access(1'b0, a, '0, rd);
      check_value(name, ref_mem[a], rd);
    end
  endtask

  //////////////////////////////////////////////////
  // Command port
  //////////////////////////////////////////////////

  task automatic send_cmd(input dma_op_e op, input logic [dma_ptr_w-1:0] pos,
                          input dma_sel_t sel, input dma_req_t req);
    dma_cmd_t c;
    c.op  = op;
    c.pos = pos;
    c.sel = sel;
    c.req = req;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic program_entry(input logic [dma_ptr_w-1:0] pos, input dma_req_t r);
    send_cmd(op_write, pos, 4'b1111, r);
    send_cmd(op_start, pos, '0, '0);
  endtask

  task automatic wait_irq(input logic [dma_ptr_w-1:0] pos);
    int n;
    n = 0;
    @(negedge clk);
    while (!irq[pos] && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!irq[pos]) begin
      $display("Timed out waiting for the interrupt of entry %0d", pos);
      errors++;
    end
  endtask

  // Both regions are read back, the untouched one must be unchanged
  task automatic finish_copy(input string name, input logic [dma_ptr_w-1:0] pos,
                             input dma_req_t r);
    wait_irq(pos);
    model_copy(r);
    verify_range(name, r.laddr, int'(r.size));
    verify_range(name, r.raddr, int'(r.size));
  endtask

  task automatic check_irq(input string name, input logic [31:0] exp);
    @(negedge clk);
    check_value(name, exp, 32'(irq));
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    dma_req_t    r;
    dma_req_t    q [dma_entries];
    logic [31:0] rd;
    void'($urandom(53731));
    errors     = 0;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    host_valid = 1'b0;
    host_req   = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Local to remote
    r = make_req(8'h00, 8'h20, 8'd8, 1'b0);
    preload_source(r);
    program_entry(2'd0, r);
    finish_copy("local_to_remote", 2'd0, r);
    send_cmd(op_ack, 2'd0, '0, '0);

    // Remote to local
    r = make_req(8'h30, 8'h40, 8'd6, 1'b1);
    preload_source(r);
    program_entry(2'd1, r);
    finish_copy("remote_to_local", 2'd1, r);
    send_cmd(op_ack, 2'd1, '0, '0);

    // Only size is selected, the new laddr and dir must be ignored
    send_cmd(op_write, 2'd2, 4'b1111, make_req(8'h50, 8'h60, 8'd3, 1'b0));
    send_cmd(op_write, 2'd2, 4'b0010, make_req(8'h70, 8'h00, 8'd5, 1'b1));
    r = make_req(8'h50, 8'h60, 8'd5, 1'b0);
    preload_source(r);
    send_cmd(op_start, 2'd2, '0, '0);
    finish_copy("partial_update", 2'd2, r);
    send_cmd(op_ack, 2'd2, '0, '0);
    check_irq("partial_update irq", 32'h0);

    // All four entries on disjoint regions
    for (int i = 0; i < dma_entries; i++) begin
      q[i] = make_req(8'h80 + 8'(i * 16), 8'hC0 + 8'(i * 16), 8'd4, 1'(i % 2));
      preload_source(q[i]);
    end
    for (int i = 0; i < dma_entries; i++) begin
      program_entry(dma_ptr_w'(i), q[i]);
    end
    for (int i = 0; i < dma_entries; i++) begin
      finish_copy("four_entries", dma_ptr_w'(i), q[i]);
    end
    check_irq("four_entries irq", 32'hF);
    send_cmd(op_ack, 2'd2, '0, '0);
    check_irq("single_ack irq", 32'hB);
    send_cmd(op_ack, 2'd0, '0, '0);
    send_cmd(op_ack, 2'd1, '0, '0);
    send_cmd(op_ack, 2'd3, '0, '0);
    check_irq("all_acked irq", 32'h0);

    // Early ack is ignored, cancel clears the finished entry
    r = make_req(8'h00, 8'h30, 8'd20, 1'b0);
    preload_source(r);
    program_entry(2'd3, r);
    check_irq("early_ack irq before", 32'h0);
    send_cmd(op_ack, 2'd3, '0, '0);
    finish_copy("early_ack", 2'd3, r);
    check_irq("early_ack irq after", 32'h8);
    send_cmd(op_cancel, 2'd3, '0, '0);
    check_irq("cancel irq", 32'h0);

    // Host reads stall behind a long copy
    host_write(8'hF0, $urandom());
    r = make_req(8'h00, 8'h40, 8'd40, 1'b0);
    preload_source(r);
    program_entry(2'd0, r);
    for (int i = 0; i < 6; i++) begin
      mem_access(1'b0, 8'hF0, '0, rd);
      check_value("host_stall", ref_mem[8'hF0], rd);
    end
    finish_copy("host_stall copy", 2'd0, r);
    send_cmd(op_ack, 2'd0, '0, '0);

    repeat (4) @(posedge clk);
    $display("Run finished with %0d data errors and %0d assertion failures",
             errors, UUT.u_checker.fail_total);
    if (errors == 0 && UUT.u_checker.fail_total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
common/dma_pkg.sv
dma_table/dma_transfer_table.sv
hdl/dma_cmd_decode.sv
hdl/dma_ctrl.sv
hdl/dma_local_mem.sv
hdl/dma_top.sv
tb/dma_checker.sv
tb/dma_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dma_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
